/* Bender.yml */
package:
  name: mem_subsystem

export_include_dirs:
  - include

sources:
  - source/mem_pkg.sv
  - source/icache.sv
  - source/bus_arbiter.sv
  - source/sram_slave.sv
  - source/mem_subsystem.sv
  - target: test
    files:
      - bench/tb_mem_subsystem.sv

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int MAX_CYCLES = 20000;
    localparam logic [31:0] SEED = 32'hef2b;

    logic     clk;
    logic     rst_n;
    logic     if_ar_valid_i;
    logic     if_ar_ready_o;
    ar_chan_t if_ar_i;
    logic     if_r_valid_o;
    logic     if_r_ready_i;
    r_chan_t  if_r_o;
    logic     d_ar_valid_i;
    logic     d_ar_ready_o;
    ar_chan_t d_ar_i;
    logic     d_r_valid_o;
    logic     d_r_ready_i;
    r_chan_t  d_r_o;
    logic     d_wr_valid_i;
    logic     d_wr_ready_o;
    aw_chan_t d_aw_i;
    w_chan_t  d_w_i;
    logic     d_b_valid_o;
    logic     d_b_ready_i;
    b_chan_t  d_b_o;

    // shadow of every written sram word, keyed by word index
    logic [`DATA_W-1:0] shadow [int];
    // reference model of the direct-mapped fetch cache
    logic               cm_valid [`IC_LINES];
    logic [28:0]        cm_addr  [`IC_LINES];
    logic [`DATA_W-1:0] cm_data  [`IC_LINES];

    // expected responses, set before each request goes out
    r_chan_t d_exp_r;
    b_chan_t d_exp_b;
    r_chan_t f_exp_r;
    logic    f_exp_hit;

    logic [31:0] rng;
    logic [31:0] f_rng;
    logic        quiet_window;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          test_err_base;
    int          test_chk_base;
    string       test_name;

    mem_subsystem i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .if_ar_valid_i (if_ar_valid_i),
        .if_ar_ready_o (if_ar_ready_o),
        .if_ar_i       (if_ar_i),
        .if_r_valid_o  (if_r_valid_o),
        .if_r_ready_i  (if_r_ready_i),
        .if_r_o        (if_r_o),
        .d_ar_valid_i  (d_ar_valid_i),
        .d_ar_ready_o  (d_ar_ready_o),
        .d_ar_i        (d_ar_i),
        .d_r_valid_o   (d_r_valid_o),
        .d_r_ready_i   (d_r_ready_i),
        .d_r_o         (d_r_o),
        .d_wr_valid_i  (d_wr_valid_i),
        .d_wr_ready_o  (d_wr_ready_o),
        .d_aw_i        (d_aw_i),
        .d_w_i         (d_w_i),
        .d_b_valid_o   (d_b_valid_o),
        .d_b_ready_i   (d_b_ready_i),
        .d_b_o         (d_b_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles, a request never completed",
                     cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    // ************************************************************
    // helpers
    // ************************************************************
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] data_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function logic [31:0] fetch_rand();
        f_rng = xorshift32(f_rng);
        return f_rng;
    endfunction

    function automatic logic in_sram_range(input logic [31:0] addr);
        return (addr >= `SRAM_BASE) && (addr < `SRAM_BASE + 8 * `SRAM_WORDS);
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - `SRAM_BASE) >> 3);
    endfunction

    // error replies carry zero data
    function automatic r_chan_t expect_read(input logic [31:0] addr);
        r_chan_t r;
        if (in_sram_range(addr)) begin
            r.data = shadow[word_index(addr)];
            r.resp = RESP_OKAY;
        end else begin
            r.data = '0;
            r.resp = RESP_SLVERR;
        end
        return r;
    endfunction

    task automatic report_value(input string what, input logic [65:0] exp,
                                input logic [65:0] act);
        err_cnt++;
        $display("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("test %s failed: %s", test_name, msg);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = err_cnt;
        test_chk_base = check_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("test %s: %0d checks, %0d errors", test_name,
                 check_cnt - test_chk_base, err_cnt - test_err_base);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // ************************************************************
    // bus transactions
    // ************************************************************
    task automatic data_write(input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] strb);
        logic [63:0] word;
        logic [31:0] r;
        logic        hs;
        if (in_sram_range(addr)) begin
            word = shadow.exists(word_index(addr)) ? shadow[word_index(addr)] : '0;
            for (int i = 0; i < `STRB_W; i++) begin
                if (strb[i]) begin
                    word[8*i +: 8] = data[8*i +: 8];
                end
            end
            shadow[word_index(addr)] = word;
            d_exp_b.resp = RESP_OKAY;
        end else begin
            d_exp_b.resp = RESP_SLVERR;
        end
        @(posedge clk);
        d_wr_valid_i <= 1'b1;
        d_aw_i.addr  <= addr;
        d_w_i.data   <= data;
        d_w_i.strb   <= strb;
        do @(posedge clk); while (!(d_wr_valid_i && d_wr_ready_o));
        d_wr_valid_i <= 1'b0;
        r = data_rand();
        d_b_ready_i  <= (r[1:0] != 2'b00);
        do begin
            @(posedge clk);
            hs = d_b_valid_o && d_b_ready_i;
            if (!hs) begin
                r = data_rand();
                d_b_ready_i <= (r[1:0] != 2'b00);
            end
        end while (!hs);
        d_b_ready_i <= 1'b0;
        check_cnt++;
    endtask

    task automatic data_read(input logic [31:0] addr);
        logic [31:0] r;
        logic        hs;
        d_exp_r = expect_read(addr);
        @(posedge clk);
        d_ar_valid_i <= 1'b1;
        d_ar_i.addr  <= addr;
        do @(posedge clk); while (!(d_ar_valid_i && d_ar_ready_o));
        d_ar_valid_i <= 1'b0;
        r = data_rand();
        d_r_ready_i  <= (r[1:0] != 2'b00);
        do begin
            @(posedge clk);
            hs = d_r_valid_o && d_r_ready_i;
            if (!hs) begin
                r = data_rand();
                d_r_ready_i <= (r[1:0] != 2'b00);
            end
        end while (!hs);
        d_r_ready_i <= 1'b0;
        check_cnt++;
    endtask

    // data writes never touch the cache model
    task automatic fetch(input logic [31:0] addr);
        int          line;
        logic [31:0] r;
        logic        hs;
        line = int'((addr >> 3) % `IC_LINES);
        if (cm_valid[line] && cm_addr[line] == addr[31:3]) begin
            f_exp_hit    = 1'b1;
            f_exp_r.data = cm_data[line];
            f_exp_r.resp = RESP_OKAY;
        end else begin
            f_exp_hit = 1'b0;
            f_exp_r   = expect_read(addr);
            if (f_exp_r.resp == RESP_OKAY) begin
                cm_valid[line] = 1'b1;
                cm_addr[line]  = addr[31:3];
                cm_data[line]  = f_exp_r.data;
            end
        end
        @(posedge clk);
        if_ar_valid_i <= 1'b1;
        if_ar_i.addr  <= addr;
        do @(posedge clk); while (!(if_ar_valid_i && if_ar_ready_o));
        if_ar_valid_i <= 1'b0;
        r = fetch_rand();
        if_r_ready_i  <= (r[1:0] != 2'b00);
        do begin
            @(posedge clk);
            hs = if_r_valid_o && if_r_ready_i;
            if (!hs) begin
                r = fetch_rand();
                if_r_ready_i <= (r[1:0] != 2'b00);
            end
        end while (!hs);
        if_r_ready_i <= 1'b0;
        check_cnt++;
    endtask

    // ************************************************************
    // checks
    // ************************************************************
    a_quiet: assert property (@(posedge clk) (cycle_cnt > 0) && quiet_window |->
        !if_r_valid_o && !d_r_valid_o && !d_b_valid_o)
        else report_failure("a response valid was high before any request");

    a_data_read: assert property (@(posedge clk) disable iff (rst_n)
        d_r_valid_o && d_r_ready_i |-> d_r_o == d_exp_r)
        else report_value("data read", $sampled(d_exp_r), $sampled(d_r_o));

    a_data_write: assert property (@(posedge clk) disable iff (rst_n)
        d_b_valid_o && d_b_ready_i |-> d_b_o == d_exp_b)
        else report_value("write response", $sampled(d_exp_b), $sampled(d_b_o));

    a_fetch: assert property (@(posedge clk) disable iff (rst_n)
        if_r_valid_o && if_r_ready_i |-> if_r_o == f_exp_r)
        else report_value("fetch", $sampled(f_exp_r), $sampled(if_r_o));

    // a hit raises r_valid on the edge after its request handshake
    a_hit_latency: assert property (@(posedge clk) disable iff (rst_n)
        if_ar_valid_i && if_ar_ready_o && f_exp_hit |=> !if_r_valid_o ##1 if_r_valid_o)
        else report_failure("fetch hit did not respond one cycle after its request");

    // ************************************************************
    // test sequence
    // ************************************************************
    initial begin
        logic [31:0] addr;
        logic [31:0] addr_b;
        logic [31:0] r;
        logic [31:0] fr;
        logic [31:0] dr;
        logic [31:0] written [$];

        rng           = SEED;
        f_rng         = data_rand();
        quiet_window  = 1'b1;
        f_exp_hit     = 1'b0;
        d_exp_r       = '0;
        d_exp_b       = '0;
        f_exp_r       = '0;
        for (int i = 0; i < `IC_LINES; i++) begin
            cm_valid[i] = 1'b0;
        end
        rst_n         = 1'b1;
        if_ar_valid_i = 1'b0;
        if_ar_i       = '0;
        if_r_ready_i  = 1'b0;
        d_ar_valid_i  = 1'b0;
        d_ar_i        = '0;
        d_r_ready_i   = 1'b0;
        d_wr_valid_i  = 1'b0;
        d_aw_i        = '0;
        d_w_i         = '0;
        d_b_ready_i   = 1'b0;

        start_test("reset");
        repeat (10) @(posedge clk);
        rst_n <= 1'b0;
        idle_cycles(5);
        check_cnt += 15;
        quiet_window = 1'b0;
        end_test();

        start_test("data write read");
        for (int i = 0; i < 8; i++) begin
            r    = data_rand();
            addr = `SRAM_BASE + 8 * (r % 64);
            written.push_back(addr);
            data_write(addr, {data_rand(), data_rand()}, 8'hff);
        end
        foreach (written[i]) begin
            r = data_rand();
            data_write(written[i], {data_rand(), data_rand()}, r[7:0]);
        end
        foreach (written[i]) begin
            data_read(written[i]);
        end
        end_test();

        start_test("fetch miss hit");
        foreach (written[i]) begin
            fetch(written[i]);
            fetch(written[i]);
        end
        end_test();

        start_test("no coherence");
        addr   = written[0];
        addr_b = addr + 8 * `IC_LINES;
        fetch(addr);
        data_write(addr, {data_rand(), data_rand()}, 8'hff);
        fetch(addr);
        data_write(addr_b, {data_rand(), data_rand()}, 8'hff);
        fetch(addr_b);
        fetch(addr);
        end_test();

        start_test("out of range");
        data_read(32'h7fff_fff8);
        data_read(`SRAM_BASE + 8 * `SRAM_WORDS);
        // low bits alias a written word
        data_write(`SRAM_BASE + 8 * `SRAM_WORDS + (written[1] - `SRAM_BASE),
                   {data_rand(), data_rand()}, 8'hff);
        data_write(32'h0000_0100, {data_rand(), data_rand()}, 8'h0f);
        data_read(written[1]);
        fetch(32'h8000_2000);
        fetch(32'h8000_2000);
        fetch(32'h7fff_fff0);
        fetch(written[1]);
        end_test();

        start_test("concurrent");
        // fetch words 64..95, data words 128..159, never shared
        for (int i = 64; i < 96; i++) begin
            data_write(`SRAM_BASE + 8 * i, {data_rand(), data_rand()}, 8'hff);
        end
        for (int i = 128; i < 160; i++) begin
            data_write(`SRAM_BASE + 8 * i, {data_rand(), data_rand()}, 8'hff);
        end
        fork
            begin
                for (int i = 0; i < 150; i++) begin
                    fr = fetch_rand();
                    idle_cycles(fr[1:0]);
                    fetch(`SRAM_BASE + 8 * (64 + fr[8 +: 5]));
                end
            end
            begin
                for (int i = 0; i < 150; i++) begin
                    dr = data_rand();
                    idle_cycles(dr[1:0]);
                    if (dr[4]) begin
                        data_write(`SRAM_BASE + 8 * (128 + dr[8 +: 5]),
                                   {data_rand(), data_rand()}, dr[23:16]);
                    end else begin
                        data_read(`SRAM_BASE + 8 * (128 + dr[8 +: 5]));
                    end
                end
            end
        join
        end_test();

        idle_cycles(2);
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
source/mem_pkg.sv
source/icache.sv
source/bus_arbiter.sv
source/sram_slave.sv
source/mem_subsystem.sv
bench/tb_mem_subsystem.sv

/* include/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8

// on-chip sram, byte addressed, 64-bit words
`define SRAM_BASE 32'h8000_0000
`define SRAM_WORDS 1024
// cycles from request accept to response valid
`define SRAM_LAT 2

// instruction cache, one word per line
`define IC_LINES 16

`endif

/* source/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    // fetch slot
    input  logic               f_ar_valid_i,
    output logic               f_ar_ready_o,
    input  mem_pkg::ar_chan_t  f_ar_i,
    output logic               f_r_valid_o,
    input  logic               f_r_ready_i,
    output mem_pkg::r_chan_t   f_r_o,
    // data slot
    input  logic               d_ar_valid_i,
    output logic               d_ar_ready_o,
    input  mem_pkg::ar_chan_t  d_ar_i,
    output logic               d_r_valid_o,
    input  logic               d_r_ready_i,
    output mem_pkg::r_chan_t   d_r_o,
    input  logic               d_wr_valid_i,
    output logic               d_wr_ready_o,
    input  mem_pkg::aw_chan_t  d_aw_i,
    input  mem_pkg::w_chan_t   d_w_i,
    output logic               d_b_valid_o,
    input  logic               d_b_ready_i,
    output mem_pkg::b_chan_t   d_b_o,
    // downstream bus
    output logic               m_ar_valid_o,
    input  logic               m_ar_ready_i,
    output mem_pkg::ar_chan_t  m_ar_o,
    input  logic               m_r_valid_i,
    output logic               m_r_ready_o,
    input  mem_pkg::r_chan_t   m_r_i,
    output logic               m_wr_valid_o,
    input  logic               m_wr_ready_i,
    output mem_pkg::aw_chan_t  m_aw_o,
    output mem_pkg::w_chan_t   m_w_o,
    input  logic               m_b_valid_i,
    output logic               m_b_ready_o,
    input  mem_pkg::b_chan_t   m_b_i
);
    import mem_pkg::*;

    arb_state_e state;
    arb_state_e gnt;
    logic       req_sent;
    logic       req_hs;
    logic       resp_hs;

    // fixed priority: data write, data read, fetch
    always_comb begin
        gnt = state;
        if (state == ARB_IDLE) begin
            if (d_wr_valid_i) begin
                gnt = ARB_DATA_WR;
            end else if (d_ar_valid_i) begin
                gnt = ARB_DATA_RD;
            end else if (f_ar_valid_i) begin
                gnt = ARB_FETCH_RD;
            end
        end
    end

    // ********************************************************
    // request steering
    // ********************************************************
    // only one request per grant goes downstream
    assign m_ar_valid_o = !req_sent && ((gnt == ARB_FETCH_RD && f_ar_valid_i) ||
                                        (gnt == ARB_DATA_RD && d_ar_valid_i));
    assign m_ar_o       = (gnt == ARB_FETCH_RD) ? f_ar_i : d_ar_i;
    assign f_ar_ready_o = (gnt == ARB_FETCH_RD) && !req_sent && m_ar_ready_i;
    assign d_ar_ready_o = (gnt == ARB_DATA_RD) && !req_sent && m_ar_ready_i;

    assign m_wr_valid_o = (gnt == ARB_DATA_WR) && !req_sent && d_wr_valid_i;
    assign m_aw_o       = d_aw_i;
    assign m_w_o        = d_w_i;
    assign d_wr_ready_o = (gnt == ARB_DATA_WR) && !req_sent && m_wr_ready_i;

    // ********************************************************
    // response steering
    // ********************************************************
    assign f_r_valid_o = (state == ARB_FETCH_RD) && m_r_valid_i;
    assign d_r_valid_o = (state == ARB_DATA_RD) && m_r_valid_i;
    assign f_r_o       = m_r_i;
    assign d_r_o       = m_r_i;
    assign m_r_ready_o = (state == ARB_FETCH_RD && f_r_ready_i) ||
                         (state == ARB_DATA_RD && d_r_ready_i);

    assign d_b_valid_o = (state == ARB_DATA_WR) && m_b_valid_i;
    assign d_b_o       = m_b_i;
    assign m_b_ready_o = (state == ARB_DATA_WR) && d_b_ready_i;

    assign req_hs  = (m_ar_valid_o && m_ar_ready_i) || (m_wr_valid_o && m_wr_ready_i);
    assign resp_hs = (m_r_valid_i && m_r_ready_o) || (m_b_valid_i && m_b_ready_o);

    // grant held from selection until its response completes
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state    <= ARB_IDLE;
            req_sent <= 1'b0;
        end else if (state == ARB_IDLE) begin
            // a pending valid cannot drop, so latch the winner now
            state    <= gnt;
            req_sent <= req_hs;
        end else begin
            if (req_hs) begin
                req_sent <= 1'b1;
            end
            if (resp_hs) begin
                state    <= ARB_IDLE;
                req_sent <= 1'b0;
            end
        end
    end

    // responses from the slave only arrive for the request it was given
    a_r_in_grant: assert property (@(posedge clk) disable iff (rst_n)
        m_r_valid_i |-> req_sent && (state inside {ARB_FETCH_RD, ARB_DATA_RD}));

    a_b_in_grant: assert property (@(posedge clk) disable iff (rst_n)
        m_b_valid_i |-> req_sent && state == ARB_DATA_WR);

endmodule

/* source/icache.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"

module icache (
    input  logic               clk,
    input  logic               rst_n,
    // fetch side
    input  logic               ar_valid_i,
    output logic               ar_ready_o,
    input  mem_pkg::ar_chan_t  ar_i,
    output logic               r_valid_o,
    input  logic               r_ready_i,
    output mem_pkg::r_chan_t   r_o,
    // bus side
    output logic               bus_ar_valid_o,
    input  logic               bus_ar_ready_i,
    output mem_pkg::ar_chan_t  bus_ar_o,
    input  logic               bus_r_valid_i,
    output logic               bus_r_ready_o,
    input  mem_pkg::r_chan_t   bus_r_i
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`IC_LINES);
    localparam int TAG_W = `ADDR_W - IDX_W - 3;

    ic_state_e          state;
    logic [`IC_LINES-1:0] line_valid;
    logic [TAG_W-1:0]   line_tag  [`IC_LINES];
    logic [`DATA_W-1:0] line_data [`IC_LINES];

    logic [`ADDR_W-1:0] req_addr;
    logic [IDX_W-1:0]   idx;
    logic [TAG_W-1:0]   tag;
    logic               hit;
    logic               ar_sent;
    logic               fetch_hs;
    logic               refill_hs;
    logic               refill_ok;
    r_chan_t            resp_q;

    // address split: tag | index | byte offset
    assign idx = req_addr[3 +: IDX_W];
    assign tag = req_addr[`ADDR_W-1 -: TAG_W];
    assign hit = line_valid[idx] && (line_tag[idx] == tag);

    assign ar_ready_o = (state == IC_IDLE);
    assign fetch_hs   = ar_valid_i && ar_ready_o;
    assign r_valid_o  = (state == IC_RESP);
    assign r_o        = resp_q;

    // one refill read per miss
    assign bus_ar_valid_o = (state == IC_REFILL) && !ar_sent;
    assign bus_ar_o.addr  = req_addr;
    assign bus_r_ready_o  = (state == IC_REFILL) && ar_sent;
    assign refill_hs      = bus_r_valid_i && bus_r_ready_o;
    assign refill_ok      = (bus_r_i.resp == RESP_OKAY);

    // ********************************************************
    // control fsm
    // ********************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state      <= IC_IDLE;
            ar_sent    <= 1'b0;
            line_valid <= '0;
        end else begin
            case (state)
                IC_IDLE: begin
                    if (fetch_hs) begin
                        state <= IC_LOOKUP;
                    end
                end
                IC_LOOKUP: begin
                    state <= hit ? IC_RESP : IC_REFILL;
                end
                IC_REFILL: begin
                    if (bus_ar_valid_o && bus_ar_ready_i) begin
                        ar_sent <= 1'b1;
                    end
                    if (refill_hs) begin
                        ar_sent <= 1'b0;
                        state   <= IC_RESP;
                        // error replies never allocate
                        if (refill_ok) begin
                            line_valid[idx] <= 1'b1;
                        end
                    end
                end
                IC_RESP: begin
                    if (r_ready_i) begin
                        state <= IC_IDLE;
                    end
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    // request address, line arrays and response word
    always_ff @(posedge clk) begin
        if (fetch_hs) begin
            req_addr <= ar_i.addr;
        end
        if (state == IC_LOOKUP && hit) begin
            resp_q.data <= line_data[idx];
            resp_q.resp <= RESP_OKAY;
        end
        if (refill_hs) begin
            resp_q <= bus_r_i;
            if (refill_ok) begin
                line_tag[idx]  <= tag;
                line_data[idx] <= bus_r_i.data;
            end
        end
    end

    // response held under back-pressure
    a_resp_stable: assert property (@(posedge clk) disable iff (rst_n)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

    // refill request held until the arbiter takes it
    a_refill_hold: assert property (@(posedge clk) disable iff (rst_n)
        bus_ar_valid_o && !bus_ar_ready_i |=> bus_ar_valid_o && $stable(bus_ar_o));

endmodule

/* source/mem_pkg.sv */
`include "mem_consts.svh"

package mem_pkg;

    // bus response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // ********************************************************
    // channel payloads
    // ********************************************************
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
    } ar_chan_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
    } aw_chan_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [`STRB_W-1:0] strb;
    } w_chan_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        resp_e              resp;
    } r_chan_t;

    typedef struct packed {
        resp_e resp;
    } b_chan_t;

    // ********************************************************
    // fsm states
    // ********************************************************
    typedef enum logic [1:0] {
        ARB_IDLE, ARB_FETCH_RD, ARB_DATA_RD, ARB_DATA_WR
    } arb_state_e;

    typedef enum logic [1:0] {
        IC_IDLE, IC_LOOKUP, IC_REFILL, IC_RESP
    } ic_state_e;

    typedef enum logic [1:0] {
        SR_IDLE, SR_WAIT, SR_RESP
    } sram_state_e;

endpackage

/* source/mem_subsystem.sv */
`timescale 1ns/10ps

module mem_subsystem (
    input  logic               clk,
    input  logic               rst_n,
    // fetch port
    input  logic               if_ar_valid_i,
    output logic               if_ar_ready_o,
    input  mem_pkg::ar_chan_t  if_ar_i,
    output logic               if_r_valid_o,
    input  logic               if_r_ready_i,
    output mem_pkg::r_chan_t   if_r_o,
    // data port
    input  logic               d_ar_valid_i,
    output logic               d_ar_ready_o,
    input  mem_pkg::ar_chan_t  d_ar_i,
    output logic               d_r_valid_o,
    input  logic               d_r_ready_i,
    output mem_pkg::r_chan_t   d_r_o,
    input  logic               d_wr_valid_i,
    output logic               d_wr_ready_o,
    input  mem_pkg::aw_chan_t  d_aw_i,
    input  mem_pkg::w_chan_t   d_w_i,
    output logic               d_b_valid_o,
    input  logic               d_b_ready_i,
    output mem_pkg::b_chan_t   d_b_o
);
    import mem_pkg::*;

    // icache to arbiter fetch slot
    logic     ic_ar_valid;
    logic     ic_ar_ready;
    ar_chan_t ic_ar;
    logic     ic_r_valid;
    logic     ic_r_ready;
    r_chan_t  ic_r;

    // arbiter to sram
    logic     m_ar_valid;
    logic     m_ar_ready;
    ar_chan_t m_ar;
    logic     m_r_valid;
    logic     m_r_ready;
    r_chan_t  m_r;
    logic     m_wr_valid;
    logic     m_wr_ready;
    aw_chan_t m_aw;
    w_chan_t  m_w;
    logic     m_b_valid;
    logic     m_b_ready;
    b_chan_t  m_b;

    icache i_icache (
        .clk            (clk),
        .rst_n          (rst_n),
        .ar_valid_i     (if_ar_valid_i),
        .ar_ready_o     (if_ar_ready_o),
        .ar_i           (if_ar_i),
        .r_valid_o      (if_r_valid_o),
        .r_ready_i      (if_r_ready_i),
        .r_o            (if_r_o),
        .bus_ar_valid_o (ic_ar_valid),
        .bus_ar_ready_i (ic_ar_ready),
        .bus_ar_o       (ic_ar),
        .bus_r_valid_i  (ic_r_valid),
        .bus_r_ready_o  (ic_r_ready),
        .bus_r_i        (ic_r)
    );

    // data port wins over fetch
    bus_arbiter i_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .f_ar_valid_i (ic_ar_valid),
        .f_ar_ready_o (ic_ar_ready),
        .f_ar_i       (ic_ar),
        .f_r_valid_o  (ic_r_valid),
        .f_r_ready_i  (ic_r_ready),
        .f_r_o        (ic_r),
        .d_ar_valid_i (d_ar_valid_i),
        .d_ar_ready_o (d_ar_ready_o),
        .d_ar_i       (d_ar_i),
        .d_r_valid_o  (d_r_valid_o),
        .d_r_ready_i  (d_r_ready_i),
        .d_r_o        (d_r_o),
        .d_wr_valid_i (d_wr_valid_i),
        .d_wr_ready_o (d_wr_ready_o),
        .d_aw_i       (d_aw_i),
        .d_w_i        (d_w_i),
        .d_b_valid_o  (d_b_valid_o),
        .d_b_ready_i  (d_b_ready_i),
        .d_b_o        (d_b_o),
        .m_ar_valid_o (m_ar_valid),
        .m_ar_ready_i (m_ar_ready),
        .m_ar_o       (m_ar),
        .m_r_valid_i  (m_r_valid),
        .m_r_ready_o  (m_r_ready),
        .m_r_i        (m_r),
        .m_wr_valid_o (m_wr_valid),
        .m_wr_ready_i (m_wr_ready),
        .m_aw_o       (m_aw),
        .m_w_o        (m_w),
        .m_b_valid_i  (m_b_valid),
        .m_b_ready_o  (m_b_ready),
        .m_b_i        (m_b)
    );

    sram_slave i_sram (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_valid_i (m_ar_valid),
        .ar_ready_o (m_ar_ready),
        .ar_i       (m_ar),
        .r_valid_o  (m_r_valid),
        .r_ready_i  (m_r_ready),
        .r_o        (m_r),
        .wr_valid_i (m_wr_valid),
        .wr_ready_o (m_wr_ready),
        .aw_i       (m_aw),
        .w_i        (m_w),
        .b_valid_o  (m_b_valid),
        .b_ready_i  (m_b_ready),
        .b_o        (m_b)
    );

endmodule

/* source/sram_slave.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"

module sram_slave (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ar_valid_i,
    output logic               ar_ready_o,
    input  mem_pkg::ar_chan_t  ar_i,
    output logic               r_valid_o,
    input  logic               r_ready_i,
    output mem_pkg::r_chan_t   r_o,
    input  logic               wr_valid_i,
    output logic               wr_ready_o,
    input  mem_pkg::aw_chan_t  aw_i,
    input  mem_pkg::w_chan_t   w_i,
    output logic               b_valid_o,
    input  logic               b_ready_i,
    output mem_pkg::b_chan_t   b_o
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int CNT_W = $clog2(`SRAM_LAT + 1);
    localparam logic [`ADDR_W-1:0] SRAM_END = `SRAM_BASE + 8 * `SRAM_WORDS;

    sram_state_e        state;
    logic [CNT_W-1:0]   lat_cnt;
    logic               is_wr;
    logic [`DATA_W-1:0] mem [`SRAM_WORDS];
    logic               rd_hs;
    logic               wr_hs;
    logic               in_range;
    logic [`ADDR_W-1:0] req_addr;
    logic [IDX_W-1:0]   idx;
    r_chan_t            r_q;
    b_chan_t            b_q;

    // writes take precedence when both arrive together
    assign wr_ready_o = (state == SR_IDLE);
    assign ar_ready_o = (state == SR_IDLE) && !wr_valid_i;
    assign wr_hs      = wr_valid_i && wr_ready_o;
    assign rd_hs      = ar_valid_i && ar_ready_o;

    assign req_addr = wr_hs ? aw_i.addr : ar_i.addr;
    assign in_range = (req_addr >= `SRAM_BASE) && (req_addr < SRAM_END);
    assign idx      = req_addr[3 +: IDX_W];

    assign r_valid_o = (state == SR_RESP) && !is_wr;
    assign b_valid_o = (state == SR_RESP) && is_wr;
    assign r_o       = r_q;
    assign b_o       = b_q;

    // ********************************************************
    // latency fsm
    // ********************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state   <= SR_IDLE;
            lat_cnt <= '0;
            is_wr   <= 1'b0;
        end else begin
            case (state)
                SR_IDLE: begin
                    if (rd_hs || wr_hs) begin
                        state   <= SR_WAIT;
                        lat_cnt <= CNT_W'(1);
                        is_wr   <= wr_hs;
                    end
                end
                SR_WAIT: begin
                    if (lat_cnt == CNT_W'(`SRAM_LAT)) begin
                        state <= SR_RESP;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                SR_RESP: begin
                    if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
                        state <= SR_IDLE;
                    end
                end
                default: state <= SR_IDLE;
            endcase
        end
    end

    // array access at accept, result held until the response goes out
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            r_q.resp <= in_range ? RESP_OKAY : RESP_SLVERR;
            r_q.data <= in_range ? mem[idx] : '0;
        end
        if (wr_hs) begin
            b_q.resp <= in_range ? RESP_OKAY : RESP_SLVERR;
            if (in_range) begin
                for (int i = 0; i < `STRB_W; i++) begin
                    if (w_i.strb[i]) begin
                        mem[idx][8*i +: 8] <= w_i.data[8*i +: 8];
                    end
                end
            end
        end
    end

    // one response at a time, each held until taken
    a_r_hold: assert property (@(posedge clk) disable iff (rst_n)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o) && !b_valid_o);

    a_b_hold: assert property (@(posedge clk) disable iff (rst_n)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o) && !r_valid_o);

endmodule
